// ==== Bender.yml ====
package:
  name: board_harness

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/harness_pkg.sv
      - hdl/i2c_bus_resolver.sv
      - hdl/pin_crossbar.sv
      - hdl/cheri_err_tracker.sv
      - hdl/board_harness.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/board_harness_tb.sv

// ==== compile.f ====
+incdir+hdl
+incdir+dv
hdl/harness_pkg.sv
hdl/i2c_bus_resolver.sv
hdl/pin_crossbar.sv
hdl/cheri_err_tracker.sv
hdl/board_harness.sv
dv/board_harness_tb.sv

// ==== dv/board_harness_vectors.svh ====
// ############################
// Board harness test tables.
// Release rule rows and pin maps.
// ############################

`ifndef BOARD_HARNESS_VECTORS_SVH
`define BOARD_HARNESS_VECTORS_SVH

// One line of an open-drain or release-high path.
typedef struct packed {
  // Value and enable of the driving side.
  logic drv;
  logic en;
  // Drive from the far side, 1 where the path has none.
  logic peer;
  // Resolved line level.
  logic exp;
} line_row_t;

// Columns are drv, en, peer, exp.
localparam logic [3:0] line_rows [8] = '{
  4'b0000, 4'b0011, 4'b0100, 4'b0110,
  4'b1000, 4'b1011, 4'b1100, 4'b1111
};

// I2C pins per bus, in bus order.
localparam int unsigned i2c_scl_pin [`HARNESS_NUM_I2C] = '{
  `INOUT_PIN_RPH_G1, `INOUT_PIN_RPH_G3_SCL, `INOUT_PIN_SCL1
};
localparam int unsigned i2c_sda_pin [`HARNESS_NUM_I2C] = '{
  `INOUT_PIN_RPH_G0, `INOUT_PIN_RPH_G2_SDA, `INOUT_PIN_SDA1
};

// SPI pins by bit of spi_bus_t: copi, cs, sck.
localparam int unsigned spi_pin [3] = '{
  `INOUT_PIN_PMOD1_2, `INOUT_PIN_PMOD1_1, `INOUT_PIN_PMOD1_4
};

// Loopback pairs.
// Sources index {inout_to, out_to}, destinations index pins_from_t.
localparam int unsigned loop_pairs = 7;
localparam int unsigned loop_src [loop_pairs] = '{
  `HARNESS_OUT_W + `INOUT_PIN_AH_TMPIO8, `HARNESS_OUT_W + `INOUT_PIN_AH_TMPIO1,
  `OUT_PIN_MB10, `OUT_PIN_MB7, `OUT_PIN_MB4,
  `HARNESS_OUT_W + `INOUT_PIN_PMOD0_8, `HARNESS_OUT_W + `INOUT_PIN_PMODC_1
};
localparam int unsigned loop_dst [loop_pairs] = '{
  `INOUT_PIN_AH_TMPIO9, `INOUT_PIN_AH_TMPIO0, `INOUT_PIN_PMOD0_1,
  `HARNESS_INOUT_W + `IN_PIN_MB8, `HARNESS_INOUT_W + `IN_PIN_MB3,
  `INOUT_PIN_PMOD0_10, `INOUT_PIN_PMODC_1
};

// Number of randomized rows.
localparam int unsigned loop_rows  = 24;
localparam int unsigned cheri_rows = 48;

`endif

// ==== dv/board_harness_tb.sv ====
// ############################
// Board harness testbench.
// Table driven checks of routing, loopback
// retiming and CHERI error tracking.
// ############################

`timescale 1ns/1ps

`include "harness_config.svh"

module board_harness_tb import harness_pkg::*; ();

  logic                             clk_i;
  logic                             rst_ni;
  sys_pins_t                        sys_pins;
  pins_from_t                       pins_from;
  i2c_line_t [`HARNESS_NUM_I2C-1:0] i2c_dev;
  i2c_line_t [`HARNESS_NUM_I2C-1:0] i2c_bus;
  spi_bus_t                         spi;
  logic                             spi_cipo;
  logic                             uart_rx;
  logic                             uart_tx;
  logic                             rs485_in;
  logic                             rs485_out;
  cheri_err_t                       errored;
  cheri_err_t                       new_err;

  // Run bookkeeping.
  int unsigned errors;
  int unsigned test_errors;
  int unsigned checks;
  int unsigned tests_run;
  int unsigned tests_bad;

  `include "board_harness_vectors.svh"

  board_harness UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sys_pins_i      (sys_pins),
    .sys_pins_o      (pins_from),
    .i2c_dev_i       (i2c_dev),
    .i2c_bus_o       (i2c_bus),
    .spi_o           (spi),
    .spi_cipo_i      (spi_cipo),
    .uart_rx_i       (uart_rx),
    .uart_tx_o       (uart_tx),
    .rs485_line_i    (rs485_in),
    .rs485_line_o    (rs485_out),
    .cheri_errored_o (errored),
    .cheri_new_err_o (new_err)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      test_errors++;
    end
  endtask

  // Reports one line per test and clears the per-test count.
  task automatic finish_test(input string name);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("[ok]   %s", name);
    end else begin
      $display("[FAIL] %s, %0d errors", name, test_errors);
      tests_bad++;
    end
    test_errors = 0;
  endtask

  // Loopback destinations in table order.
  function automatic logic [loop_pairs-1:0] loop_bits();
    logic [loop_pairs-1:0] v;
    for (int p = 0; p < loop_pairs; p++) begin
      v[p] = pins_from[loop_dst[p]];
    end
    return v;
  endfunction

  // Loopback sources as driven now.
  function automatic logic [loop_pairs-1:0] loop_expect();
    logic [`HARNESS_INOUT_W+`HARNESS_OUT_W-1:0] src;
    logic [loop_pairs-1:0]                      v;
    src = {sys_pins.inout_to, sys_pins.out_to};
    for (int p = 0; p < loop_pairs; p++) begin
      v[p] = src[loop_src[p]];
    end
    return v;
  endfunction

  task automatic wait_cleared(input int unsigned max_cycles, output bit ok);
    int unsigned n;
    n = 0;
    while ((errored !== '0 || new_err !== '0 || loop_bits() !== '0) && n < max_cycles) begin
      @(negedge clk_i);
      n++;
    end
    ok = (errored === '0 && new_err === '0 && loop_bits() === '0);
  endtask

  initial begin
    line_row_t                          row;
    line_row_t                          rx_row;
    int unsigned                        pin;
    logic [2*`HARNESS_NUM_I2C-1:0]      exp_bus;
    spi_bus_t                           exp_spi;
    logic [loop_pairs-1:0]              exp_loop;
    cheri_err_t                         errored_m;
    cheri_err_t                         exp_new;
    cheri_err_t                         err;
    cheri_err_t                         all_err;
    bit                                 ok;
    void'($urandom(32'h91cb));
    {errors, test_errors, checks, tests_run, tests_bad} = '0;
    all_err = '1;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    sys_pins = '0;
    i2c_dev = '1;
    spi_cipo = 1'b1;
    uart_rx = 1'b1;
    rs485_in = 1'b1;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    wait_cleared(16, ok);
    if (!ok) begin
      $display("timeout: registered outputs did not clear after reset release");
      test_errors++;
    end
    finish_test("reset release");

    // Every row on every line of every bus.
    for (int b = 0; b < `HARNESS_NUM_I2C; b++) begin
      for (int l = 0; l < 2; l++) begin
        for (int r = 0; r < 8; r++) begin
          row = line_rows[r];
          pin = l ? i2c_scl_pin[b] : i2c_sda_pin[b];
          @(negedge clk_i);
          sys_pins.inout_to = '0;
          sys_pins.inout_en = '0;
          sys_pins.inout_to[pin] = row.drv;
          sys_pins.inout_en[pin] = row.en;
          i2c_dev = '1;
          i2c_dev[b][l] = row.peer;
          // Bit 1 of each bus is scl, bit 0 sda.
          exp_bus = '1;
          exp_bus[2*b+l] = row.exp;
          #2;
          check_val("i2c_bus_o", i2c_bus, exp_bus);
          check_val("sys_pins_o.inout_from i2c pin", pins_from.inout_from[pin], row.exp);
          check_val("sys_pins_o.inout_from scl0/sda0",
                    pins_from.inout_from[`INOUT_PIN_SDA0] & pins_from.inout_from[`INOUT_PIN_SCL0],
                    1'b1);
        end
      end
    end
    i2c_dev = '1;
    finish_test("i2c resolution");

    // The flash has no drive of its own on these lines.
    for (int k = 0; k < 3; k++) begin
      for (int r = 1; r < 8; r += 2) begin
        row = line_rows[r];
        @(negedge clk_i);
        sys_pins.inout_to = '0;
        sys_pins.inout_en = '0;
        sys_pins.inout_to[spi_pin[k]] = row.drv;
        sys_pins.inout_en[spi_pin[k]] = row.en;
        spi_cipo = ~row.drv;
        exp_spi = '1;
        exp_spi[k] = row.exp;
        #2;
        check_val("spi_o", spi, exp_spi);
        check_val("sys_pins_o.inout_from[PMOD1_3]", pins_from.inout_from[`INOUT_PIN_PMOD1_3],
                  spi_cipo);
      end
    end
    finish_test("spi mapping");

    // Second pass flips the receive enable against the transmit enable.
    for (int q = 0; q < 2; q++) begin
      for (int r = 1; r < 8; r += 2) begin
        row = line_rows[r];
        rx_row = line_rows[r ^ (2 * q)];
        @(negedge clk_i);
        sys_pins.out_to[`OUT_PIN_SER0_TX] = row.drv;
        sys_pins.out_to[`OUT_PIN_RS485_TX] = row.drv;
        sys_pins.rs485_tx_en = row.en;
        sys_pins.rs485_rx_en = rx_row.en;
        uart_rx = ~row.drv;
        rs485_in = rx_row.drv;
        #2;
        check_val("uart_tx_o", uart_tx, row.drv);
        check_val("sys_pins_o.in_from[SER0_RX]", pins_from.in_from[`IN_PIN_SER0_RX], uart_rx);
        check_val("rs485_line_o", rs485_out, row.exp);
        check_val("sys_pins_o.in_from[RS485_RX]", pins_from.in_from[`IN_PIN_RS485_RX],
                  rx_row.exp);
      end
    end
    finish_test("uart and rs485");

    // Sources have stayed low since reset.
    @(negedge clk_i);
    check_val("sys_pins_o loopback after reset", loop_bits(), '0);
    exp_loop = '0;
    for (int i = 0; i < loop_rows; i++) begin
      sys_pins.out_to = out_pins_t'($urandom);
      sys_pins.inout_to = inout_pins_t'($urandom);
      #2;
      check_val("sys_pins_o loopback before edge", loop_bits(), exp_loop);
      exp_loop = loop_expect();
      @(negedge clk_i);
      check_val("sys_pins_o loopback after edge", loop_bits(), exp_loop);
    end
    finish_test("loopback");

    // Sparse vectors so that latching builds up over several rows.
    check_val("cheri_errored_o at start", errored, '0);
    errored_m = '0;
    for (int i = 0; i < cheri_rows; i++) begin
      err = cheri_err_t'($urandom) & cheri_err_t'($urandom);
      sys_pins.cheri_err = err;
      @(negedge clk_i);
      exp_new = err & ~errored_m;
      errored_m = errored_m | err;
      check_val("cheri_new_err_o", new_err, exp_new);
      check_val("cheri_errored_o", errored, errored_m);
    end
    finish_test("cheri tracking");

    sys_pins.out_to = '1;
    sys_pins.inout_to = '1;
    sys_pins.cheri_err = all_err;
    @(negedge clk_i);
    rst_ni = 1'b0;
    #2;
    check_val("cheri_errored_o in reset", errored, '0);
    check_val("cheri_new_err_o in reset", new_err, '0);
    check_val("sys_pins_o loopback in reset", loop_bits(), '0);
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Bits latched before reset pulse once more.
    check_val("cheri_new_err_o after reset", new_err, all_err);
    check_val("cheri_errored_o after reset", errored, all_err);
    check_val("sys_pins_o loopback after reset", loop_bits(), {loop_pairs{1'b1}});
    @(negedge clk_i);
    check_val("cheri_new_err_o held error", new_err, '0);
    finish_test("mid-run reset");

    $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hdl/board_harness.sv ====
// ############################
// Board harness top level.
// Joins the system pin vectors to the I2C, SPI,
// UART and RS485 models and tracks CHERI errors.
// ############################

`timescale 1ns/1ps

`include "harness_config.svh"

module board_harness import harness_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,

  // System pins.
  input  sys_pins_t                          sys_pins_i,
  output pins_from_t                         sys_pins_o,

  // I2C device models.
  input  i2c_line_t [`HARNESS_NUM_I2C-1:0] i2c_dev_i,
  output i2c_line_t [`HARNESS_NUM_I2C-1:0] i2c_bus_o,

  // SPI flash model.
  output spi_bus_t                           spi_o,
  input  logic                               spi_cipo_i,

  // UART model.
  input  logic                               uart_rx_i,
  output logic                               uart_tx_o,

  // RS485 model.
  input  logic                               rs485_line_i,
  output logic                               rs485_line_o,

  // CHERI error status.
  output cheri_err_t                         cheri_errored_o,
  output cheri_err_t                         cheri_new_err_o
);

  // Returned pins from each block.
  inout_pins_t i2c_inout_from;
  pins_from_t  i2c_pins;
  pins_from_t  xbar_pins;

  // I2C buses only touch bidirectional pins.
  i2c_bus_resolver u_i2c_bus_resolver (
    .inout_to_i   (sys_pins_i.inout_to),
    .inout_en_i   (sys_pins_i.inout_en),
    .dev_drive_i  (i2c_dev_i),
    .bus_o        (i2c_bus_o),
    .inout_from_o (i2c_inout_from)
  );

  pin_crossbar u_pin_crossbar (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .out_i         (sys_pins_i.out_to),
    .inout_to_i    (sys_pins_i.inout_to),
    .inout_en_i    (sys_pins_i.inout_en),
    .rs485_tx_en_i (sys_pins_i.rs485_tx_en),
    .rs485_rx_en_i (sys_pins_i.rs485_rx_en),
    .spi_o         (spi_o),
    .spi_cipo_i    (spi_cipo_i),
    .uart_rx_i     (uart_rx_i),
    .uart_tx_o     (uart_tx_o),
    .rs485_line_i  (rs485_line_i),
    .rs485_line_o  (rs485_line_o),
    .pins_o        (xbar_pins)
  );

  cheri_err_tracker u_cheri_err_tracker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .err_i     (sys_pins_i.cheri_err),
    .errored_o (cheri_errored_o),
    .new_err_o (cheri_new_err_o)
  );

  // The resolver owns no input pins.
  assign i2c_pins.in_from    = '0;
  assign i2c_pins.inout_from = i2c_inout_from;

  // Blocks own disjoint bits and leave the rest at zero, so OR merges them.
  assign sys_pins_o = i2c_pins | xbar_pins;

endmodule

// ==== hdl/cheri_err_tracker.sv ====
// ############################
// CHERI error tracker.
// Latches each error class once and pulses on
// its first occurrence.
// ############################

`timescale 1ns/1ps

module cheri_err_tracker import harness_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Raw error lines, these toggle since they drive board LEDs.
  input  cheri_err_t err_i,

  // Every class seen since reset.
  output cheri_err_t errored_o,
  // One cycle pulse per class on its first occurrence.
  output cheri_err_t new_err_o
);

  cheri_err_t errored_q;
  cheri_err_t new_err_q;
  cheri_err_t first_seen;

  // Classes active now that have not been latched yet.
  assign first_seen = err_i & ~errored_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errored_q <= '0;
      new_err_q <= '0;
    end else begin
      // Sticky until reset.
      errored_q <= errored_q | err_i;
      // Clears itself on the next edge once the class is latched.
      new_err_q <= first_seen;
    end
  end

  assign errored_o = errored_q;
  assign new_err_o = new_err_q;

endmodule

// ==== hdl/harness_config.svh ====
// ############################
// Board harness configuration.
// Pin vector widths and pin index map.
// ############################

`ifndef HARNESS_CONFIG_SVH
`define HARNESS_CONFIG_SVH

// Pin vector widths.
`define HARNESS_OUT_W       5
`define HARNESS_IN_W        4
`define HARNESS_INOUT_W     20

// Modelled I2C buses and CHERI error bits.
`define HARNESS_NUM_I2C     3
`define HARNESS_CHERI_ERR_W 9

// Output pins, system to board.
`define OUT_PIN_SER0_TX     0
`define OUT_PIN_RS485_TX    1
`define OUT_PIN_MB4         2
`define OUT_PIN_MB7         3
`define OUT_PIN_MB10        4

// Input pins, board to system.
`define IN_PIN_SER0_RX      0
`define IN_PIN_RS485_RX     1
`define IN_PIN_MB3          2
`define IN_PIN_MB8          3

// Bidirectional pins.
`define INOUT_PIN_SCL0       0
`define INOUT_PIN_SDA0       1
`define INOUT_PIN_SCL1       2
`define INOUT_PIN_SDA1       3
`define INOUT_PIN_RPH_G0     4
`define INOUT_PIN_RPH_G1     5
`define INOUT_PIN_RPH_G2_SDA 6
`define INOUT_PIN_RPH_G3_SCL 7
`define INOUT_PIN_PMOD1_1    8
`define INOUT_PIN_PMOD1_2    9
`define INOUT_PIN_PMOD1_3    10
`define INOUT_PIN_PMOD1_4    11
`define INOUT_PIN_PMOD0_1    12
`define INOUT_PIN_PMOD0_8    13
`define INOUT_PIN_PMOD0_10   14
`define INOUT_PIN_PMODC_1    15
`define INOUT_PIN_AH_TMPIO0  16
`define INOUT_PIN_AH_TMPIO1  17
`define INOUT_PIN_AH_TMPIO8  18
`define INOUT_PIN_AH_TMPIO9  19

`endif

// ==== hdl/harness_pkg.sv ====
// ############################
// Board harness types.
// Pin vectors and bus bundles shared by the harness blocks.
// ############################

`include "harness_config.svh"

package harness_pkg;

  // Flat pin vectors as seen from the system.
  typedef logic [`HARNESS_OUT_W-1:0] out_pins_t;
  typedef logic [`HARNESS_IN_W-1:0] in_pins_t;
  typedef logic [`HARNESS_INOUT_W-1:0] inout_pins_t;

  // One bit per CHERI exception class.
  typedef logic [`HARNESS_CHERI_ERR_W-1:0] cheri_err_t;

  // Everything the system drives towards the board.
  typedef struct packed {
    // Plain outputs.
    out_pins_t   out_to;
    // Bidirectional pin values and their output enables.
    inout_pins_t inout_to;
    inout_pins_t inout_en;
    // RS485 transceiver direction control.
    logic        rs485_tx_en;
    logic        rs485_rx_en;
    // Raw CHERI error lines, modulated for LEDs on the board.
    cheri_err_t  cheri_err;
  } sys_pins_t;

  // Everything the board returns to the system.
  typedef struct packed {
    in_pins_t    in_from;
    inout_pins_t inout_from;
  } pins_from_t;

  // One I2C bus, clock and data.
  typedef struct packed {
    logic scl;
    logic sda;
  } i2c_line_t;

  // Controller side of the SPI flash port.
  typedef struct packed {
    logic sck;
    // Chip select, active low.
    logic cs;
    logic copi;
  } spi_bus_t;

endpackage

// ==== hdl/i2c_bus_resolver.sv ====
// ############################
// I2C bus resolver.
// Open-drain wired AND between the system I2C
// controllers and the external device models.
// ############################

`timescale 1ns/1ps

`include "harness_config.svh"

module i2c_bus_resolver import harness_pkg::*; (
  input  inout_pins_t                        inout_to_i,
  input  inout_pins_t                        inout_en_i,
  input  i2c_line_t [`HARNESS_NUM_I2C-1:0] dev_drive_i,
  output i2c_line_t [`HARNESS_NUM_I2C-1:0] bus_o,
  output inout_pins_t                        inout_from_o
);

  // Pin positions per bus.
  // Bus 0 is the HAT ID EEPROM, bus 1 the HAT secondary bus, bus 2 is QWIIC1.
  localparam int unsigned scl_idx [`HARNESS_NUM_I2C] = '{
    `INOUT_PIN_RPH_G1,
    `INOUT_PIN_RPH_G3_SCL,
    `INOUT_PIN_SCL1
  };
  localparam int unsigned sda_idx [`HARNESS_NUM_I2C] = '{
    `INOUT_PIN_RPH_G0,
    `INOUT_PIN_RPH_G2_SDA,
    `INOUT_PIN_SDA1
  };

  // Controller side after release, one entry per bus.
  i2c_line_t [`HARNESS_NUM_I2C-1:0] ctrl_line;
  // Resolved bus state.
  i2c_line_t [`HARNESS_NUM_I2C-1:0] bus_line;

  for (genvar b = 0; b < `HARNESS_NUM_I2C; b++) begin : g_bus
    // A controller that is not driving lets the pull-up win.
    assign ctrl_line[b].scl = inout_en_i[scl_idx[b]] ? inout_to_i[scl_idx[b]] : 1'b1;
    assign ctrl_line[b].sda = inout_en_i[sda_idx[b]] ? inout_to_i[sda_idx[b]] : 1'b1;

    // Either side can pull low.
    assign bus_line[b].scl = ctrl_line[b].scl & dev_drive_i[b].scl;
    assign bus_line[b].sda = ctrl_line[b].sda & dev_drive_i[b].sda;
  end

  // The device models see the real bus, including their own drive.
  assign bus_o = bus_line;

  // The controller reads back the same bus so that it sees no contention.
  always_comb begin
    inout_from_o = '0;
    for (int unsigned b = 0; b < `HARNESS_NUM_I2C; b++) begin
      inout_from_o[scl_idx[b]] = bus_line[b].scl;
      inout_from_o[sda_idx[b]] = bus_line[b].sda;
    end
    // SCL0 and SDA0 have no model, only the board pull-ups.
    inout_from_o[`INOUT_PIN_SCL0] = 1'b1;
    inout_from_o[`INOUT_PIN_SDA0] = 1'b1;
  end

endmodule

// ==== hdl/pin_crossbar.sv ====
// ############################
// Pin crossbar.
// Routes SPI flash, UART and RS485, and retimes
// the pin loopback pairs through one register.
// ############################

`timescale 1ns/1ps

`include "harness_config.svh"

module pin_crossbar import harness_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // System side.
  input  out_pins_t   out_i,
  input  inout_pins_t inout_to_i,
  input  inout_pins_t inout_en_i,
  input  logic        rs485_tx_en_i,
  input  logic        rs485_rx_en_i,

  // SPI flash on PMOD1.
  output spi_bus_t    spi_o,
  input  logic        spi_cipo_i,

  // System UART.
  input  logic        uart_rx_i,
  output logic        uart_tx_o,

  // RS485 line.
  input  logic        rs485_line_i,
  output logic        rs485_line_o,

  // Pins returned to the system, only the bits owned here are set.
  output pins_from_t  pins_o
);

  // Number of retimed loopback pairs.
  localparam int unsigned num_loop = 7;

  logic [num_loop-1:0] loop_d;
  logic [num_loop-1:0] loop_q;
  logic                rs485_rx;

  // SPI flash lines, released high when the controller does not drive them.
  assign spi_o.cs   = inout_en_i[`INOUT_PIN_PMOD1_1] ? inout_to_i[`INOUT_PIN_PMOD1_1] : 1'b1;
  assign spi_o.copi = inout_en_i[`INOUT_PIN_PMOD1_2] ? inout_to_i[`INOUT_PIN_PMOD1_2] : 1'b1;
  assign spi_o.sck  = inout_en_i[`INOUT_PIN_PMOD1_4] ? inout_to_i[`INOUT_PIN_PMOD1_4] : 1'b1;

  // UART transmit goes straight out.
  assign uart_tx_o = out_i[`OUT_PIN_SER0_TX];

  // The transceiver only drives the line while transmit is enabled.
  // An idle line sits at the mark level.
  assign rs485_line_o = rs485_tx_en_i ? out_i[`OUT_PIN_RS485_TX] : 1'b1;

  // With the receiver off the system sees an idle line.
  assign rs485_rx = rs485_rx_en_i ? rs485_line_i : 1'b1;

  // Loopback sources, most significant first.
  // Order must match the unpacking below.
  assign loop_d = {
    inout_to_i[`INOUT_PIN_AH_TMPIO8],
    inout_to_i[`INOUT_PIN_AH_TMPIO1],
    // mikroBUS PWM back into PMOD0.
    out_i[`OUT_PIN_MB10],
    // mikroBUS UART TX to RX.
    out_i[`OUT_PIN_MB7],
    // mikroBUS SPI COPI to CIPO.
    out_i[`OUT_PIN_MB4],
    inout_to_i[`INOUT_PIN_PMOD0_8],
    // PMODC pin 1 loops onto itself.
    inout_to_i[`INOUT_PIN_PMODC_1]
  };

  // One register stage breaks the net-level loop from outputs back to inputs.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loop_q <= '0;
    end else begin
      loop_q <= loop_d;
    end
  end

  // Assemble the returned pins.
  // Bits not listed here belong to other blocks and stay zero.
  always_comb begin
    pins_o = '0;

    // UART and RS485 receive.
    pins_o.in_from[`IN_PIN_SER0_RX]  = uart_rx_i;
    pins_o.in_from[`IN_PIN_RS485_RX] = rs485_rx;

    // SPI flash data back to the controller.
    pins_o.inout_from[`INOUT_PIN_PMOD1_3] = spi_cipo_i;

    // Retimed loopback destinations.
    pins_o.inout_from[`INOUT_PIN_AH_TMPIO9] = loop_q[6];
    pins_o.inout_from[`INOUT_PIN_AH_TMPIO0] = loop_q[5];
    pins_o.inout_from[`INOUT_PIN_PMOD0_1]   = loop_q[4];
    pins_o.in_from[`IN_PIN_MB8]             = loop_q[3];
    pins_o.in_from[`IN_PIN_MB3]             = loop_q[2];
    pins_o.inout_from[`INOUT_PIN_PMOD0_10]  = loop_q[1];
    pins_o.inout_from[`INOUT_PIN_PMODC_1]   = loop_q[0];
  end

endmodule
